// File: ppu_settings.svh
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// frame geometry, one dot per clk
`define PPU_DOTS_PER_LINE   341
`define PPU_LINES_PER_FRAME 262
`define PPU_VISIBLE_DOTS    256

// scanline numbering
`define PPU_PRE_LINE        0
`define PPU_FIRST_VIS_LINE  1
`define PPU_LAST_VIS_LINE   240
`define PPU_VBLANK_LINE     241

// nmi low time in dots
`define PPU_NMI_DOTS        3

// left column clip width
`define PPU_CLIP_DOTS       8

`define PPU_PAL_ENTRIES     32

// keeps only the luma bits of a colour
`define PPU_GREY_MASK       6'h30

`endif

// File: ppu_pkg.sv
package ppu_pkg;

    // cpu visible registers
    typedef enum logic [2:0] {
        REG_CTRL     = 3'd0,
        REG_MASK     = 3'd1,
        REG_STATUS   = 3'd2,
        REG_PAL_ADDR = 3'd3,
        REG_PAL_DATA = 3'd4
    } reg_sel_t;

    typedef struct packed {
        logic       nmi_en;
        logic [6:0] rsvd;
    } ctrl_t;

    typedef struct packed {
        logic [2:0] rsvd;
        logic       sp_en;
        logic       bg_en;
        logic       sp_left;
        logic       bg_left;
        logic       grey;
    } mask_t;

    // one written byte, seen as control or mask
    typedef union packed {
        ctrl_t      ctrl;
        mask_t      mask;
        logic [7:0] raw;
    } reg_word_u;

    typedef struct packed {
        reg_sel_t   sel;
        logic       write;
        logic [7:0] data;
    } cpu_cmd_t;

    typedef struct packed {
        logic [3:0] bg_idx;
        logic [3:0] sp_idx;
        logic       sp_prio;
        logic       sp_zero;
    } pix_in_t;

    typedef enum logic [1:0] {
        PRE_SL,
        VIS_SL,
        POST_SL,
        VBLANK_SL
    } vphase_t;

endpackage

// File: ppu_frame_timing.sv
`include "ppu_settings.svh"

module ppu_frame_timing (
    input  logic             clk,
    input  logic             rst_n,
    output logic [8:0]       dot,
    output logic [8:0]       line,
    output ppu_pkg::vphase_t phase,
    output logic             line_wr,
    output logic             line_end,
    output logic             vblank_set,
    output logic             flags_clr,
    output logic             nmi_window
);

    logic [8:0]       line_nxt;
    ppu_pkg::vphase_t phase_nxt;

    assign line_end = (dot == 9'(`PPU_DOTS_PER_LINE - 1));
    assign line_nxt = (line == 9'(`PPU_LINES_PER_FRAME - 1)) ? 9'd0 : line + 9'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dot  <= '0;
            line <= '0;
        end else if (line_end) begin
            dot  <= '0;
            line <= line_nxt;
        end else begin
            dot <= dot + 9'd1;
        end
    end

    // vertical phase only moves at the end of a line
    always_comb begin
        phase_nxt = phase;
        if (line_end) begin
            case (phase)
                ppu_pkg::PRE_SL:
                    if (line_nxt == 9'(`PPU_FIRST_VIS_LINE)) phase_nxt = ppu_pkg::VIS_SL;
                ppu_pkg::VIS_SL:
                    if (line == 9'(`PPU_LAST_VIS_LINE)) phase_nxt = ppu_pkg::POST_SL;
                ppu_pkg::POST_SL:
                    if (line == 9'(`PPU_VBLANK_LINE)) phase_nxt = ppu_pkg::VBLANK_SL;
                ppu_pkg::VBLANK_SL:
                    if (line_nxt == 9'(`PPU_PRE_LINE)) phase_nxt = ppu_pkg::PRE_SL;
                default:
                    phase_nxt = ppu_pkg::PRE_SL;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= ppu_pkg::PRE_SL;
        end else begin
            phase <= phase_nxt;
        end
    end

    // dot-exact strobes
    assign line_wr    = (phase == ppu_pkg::VIS_SL) && (dot < 9'(`PPU_VISIBLE_DOTS));
    assign vblank_set = (phase == ppu_pkg::POST_SL) && (dot == 9'd0);
    assign flags_clr  = (phase == ppu_pkg::PRE_SL) && (dot == 9'd0);
    assign nmi_window = (phase == ppu_pkg::POST_SL) && (dot < 9'(`PPU_NMI_DOTS));

endmodule

// File: ppu_cpu_regs.sv
module ppu_cpu_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cpu_req,
    input  ppu_pkg::cpu_cmd_t cpu_cmd,
    input  logic              vblank_set,
    input  logic              flags_clr,
    input  logic              nmi_window,
    input  logic              sp_zero_set,
    input  logic [5:0]        pal_rdata,
    output logic              cpu_ack,
    output logic [7:0]        cpu_rdata,
    output ppu_pkg::ctrl_t    ctrl,
    output ppu_pkg::mask_t    mask,
    output logic [4:0]        pal_waddr,
    output logic              pal_we,
    output logic [5:0]        pal_wdata,
    output logic              nmi_n
);

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_WAIT,
        HS_ACK
    } hs_state_t;

    hs_state_t          hs_state;
    logic               access;
    logic               stat_rd;
    logic               vblank;
    logic               sp_zero_hit;
    logic [4:0]         pal_ptr;
    logic [7:0]         rd_mux;
    ppu_pkg::reg_word_u word;

    // req seen on two edges in a row, then the access happens as ack rises
    assign access  = (hs_state == HS_WAIT) && cpu_req;
    assign stat_rd = access && !cpu_cmd.write && (cpu_cmd.sel == ppu_pkg::REG_STATUS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_state <= HS_IDLE;
            cpu_ack  <= 1'b0;
        end else begin
            case (hs_state)
                HS_IDLE: begin
                    if (cpu_req) hs_state <= HS_WAIT;
                end
                HS_WAIT: begin
                    hs_state <= cpu_req ? HS_ACK : HS_IDLE;
                    cpu_ack  <= cpu_req;
                end
                HS_ACK: begin
                    if (!cpu_req) begin
                        hs_state <= HS_IDLE;
                        cpu_ack  <= 1'b0;
                    end
                end
                default: begin
                    hs_state <= HS_IDLE;
                    cpu_ack  <= 1'b0;
                end
            endcase
        end
    end

    assign word.raw = cpu_cmd.data;

    always_comb begin
        case (cpu_cmd.sel)
            ppu_pkg::REG_CTRL:     rd_mux = ctrl;
            ppu_pkg::REG_MASK:     rd_mux = mask;
            ppu_pkg::REG_STATUS:   rd_mux = {vblank, sp_zero_hit, 6'd0};
            ppu_pkg::REG_PAL_ADDR: rd_mux = {3'd0, pal_ptr};
            ppu_pkg::REG_PAL_DATA: rd_mux = {2'd0, pal_rdata};
            default:               rd_mux = 8'd0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl      <= '0;
            mask      <= '0;
            pal_ptr   <= '0;
            cpu_rdata <= '0;
        end else if (access) begin
            // writes echo the data byte
            cpu_rdata <= cpu_cmd.write ? cpu_cmd.data : rd_mux;
            if (cpu_cmd.write && cpu_cmd.sel == ppu_pkg::REG_CTRL) ctrl <= word.ctrl;
            if (cpu_cmd.write && cpu_cmd.sel == ppu_pkg::REG_MASK) mask <= word.mask;
            if (cpu_cmd.write && cpu_cmd.sel == ppu_pkg::REG_PAL_ADDR) begin
                pal_ptr <= cpu_cmd.data[4:0];
            end
            // data port steps the pointer, wraps at 31
            if (cpu_cmd.sel == ppu_pkg::REG_PAL_DATA) pal_ptr <= pal_ptr + 5'd1;
        end
    end

    assign pal_waddr = pal_ptr;
    assign pal_we    = access && cpu_cmd.write && (cpu_cmd.sel == ppu_pkg::REG_PAL_DATA);
    assign pal_wdata = cpu_cmd.data[5:0];

    // status flags, clear beats set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vblank      <= 1'b0;
            sp_zero_hit <= 1'b0;
        end else begin
            if (flags_clr || stat_rd) begin
                vblank <= 1'b0;
            end else if (vblank_set) begin
                vblank <= 1'b1;
            end
            if (flags_clr) begin
                sp_zero_hit <= 1'b0;
            end else if (sp_zero_set) begin
                sp_zero_hit <= 1'b1;
            end
        end
    end

    assign nmi_n = !(nmi_window && ctrl.nmi_en);

endmodule

// File: ppu_palette_ram.sv
`include "ppu_settings.svh"

module ppu_palette_ram (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       we,
    input  logic [4:0] waddr,
    input  logic [5:0] wdata,
    input  logic [4:0] raddr_a,
    input  logic [4:0] raddr_b,
    output logic [5:0] rdata_a,
    output logic [5:0] rdata_b
);

    logic [5:0] pal_mem [`PPU_PAL_ENTRIES];

    // sprite backdrops 10/14/18/1c share the bg entries
    function automatic logic [4:0] pal_map(input logic [4:0] addr);
        return (addr[4] && addr[1:0] == 2'b00) ? {1'b0, addr[3:0]} : addr;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PPU_PAL_ENTRIES; i++) pal_mem[i] <= '0;
        end else if (we) begin
            pal_mem[pal_map(waddr)] <= wdata;
        end
    end

    // port a for rendering, port b for the cpu
    assign rdata_a = pal_mem[pal_map(raddr_a)];
    assign rdata_b = pal_mem[pal_map(raddr_b)];

endmodule

// File: ppu_pixel_mux.sv
`include "ppu_settings.svh"

module ppu_pixel_mux (
    input  ppu_pkg::pix_in_t pix,
    input  logic [8:0]       dot,
    input  ppu_pkg::mask_t   mask,
    input  logic             line_wr,
    input  logic [5:0]       pal_color,
    output logic [4:0]       pal_addr,
    output logic [5:0]       pixel,
    output logic             sp_zero_set
);

    logic       in_clip;
    logic [3:0] bg_idx;
    logic [3:0] sp_idx;
    logic       bg_opq;
    logic       sp_opq;

    assign in_clip = (dot < 9'(`PPU_CLIP_DOTS));

    // per-layer enable and left column clip
    assign bg_idx = (!mask.bg_en || (!mask.bg_left && in_clip)) ? 4'd0 : pix.bg_idx;
    assign sp_idx = (!mask.sp_en || (!mask.sp_left && in_clip)) ? 4'd0 : pix.sp_idx;

    // colour 0 of any palette is transparent
    assign bg_opq = (bg_idx[1:0] != 2'b00);
    assign sp_opq = (sp_idx[1:0] != 2'b00);

    // sprite wins unless background is opaque and sprite sits behind
    always_comb begin
        if (sp_opq && (!bg_opq || !pix.sp_prio)) begin
            pal_addr = {1'b1, sp_idx};
        end else begin
            pal_addr = {1'b0, bg_idx};
        end
    end

    assign pixel = mask.grey ? (pal_color & `PPU_GREY_MASK) : pal_color;

    assign sp_zero_set = line_wr && pix.sp_zero && bg_opq && sp_opq;

endmodule

// File: ppu_line_buffer.sv
`include "ppu_settings.svh"

module ppu_line_buffer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       line_wr,
    input  logic [7:0] wr_idx,
    input  logic [5:0] wr_pixel,
    input  logic       line_end,
    input  logic [7:0] rd_idx,
    output logic [5:0] rd_pixel
);

    logic [5:0] bank_mem [2][`PPU_VISIBLE_DOTS];
    logic       wr_bank;
    logic       rd_bank;
    logic [1:0] filled;
    logic       wr_q;
    logic [7:0] idx_q;
    logic [5:0] pix_q;

    // display side always reads the bank not being filled
    assign rd_bank = ~wr_bank;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_bank <= 1'b0;
            wr_q    <= 1'b0;
            filled  <= 2'b00;
        end else begin
            wr_q <= line_wr;
            if (line_end) wr_bank <= ~wr_bank;
            if (wr_q) filled[wr_bank] <= 1'b1;
        end
    end

    // write lands one cycle after its dot
    always_ff @(posedge clk) begin
        idx_q <= wr_idx;
        pix_q <= wr_pixel;
        if (wr_q) bank_mem[wr_bank][idx_q] <= pix_q;
    end

    // a bank never written since reset shows black
    assign rd_pixel = filled[rd_bank] ? bank_mem[rd_bank][rd_idx] : 6'd0;

endmodule

// File: ppu_top.sv
module ppu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cpu_req,
    input  ppu_pkg::cpu_cmd_t cpu_cmd,
    input  ppu_pkg::pix_in_t  pix_in,
    input  logic [7:0]        line_idx,
    output logic              cpu_ack,
    output logic [7:0]        cpu_rdata,
    output logic              nmi_n,
    output logic [5:0]        line_pixel,
    output ppu_pkg::ctrl_t    ctrl,
    output ppu_pkg::mask_t    mask
);

    logic [8:0]       dot;
    logic [8:0]       line;
    logic             line_wr;
    logic             line_end;
    logic             vblank_set;
    logic             flags_clr;
    logic             nmi_window;
    logic             sp_zero_set;
    logic [4:0]       pal_waddr;
    logic             pal_we;
    logic [5:0]       pal_wdata;
    logic [5:0]       pal_cpu_rdata;
    logic [4:0]       pal_addr;
    logic [5:0]       pal_color;
    logic [5:0]       pixel;

    ppu_frame_timing timing_i (
        .clk, .rst_n, .dot, .line, .phase(), .line_wr, .line_end,
        .vblank_set, .flags_clr, .nmi_window
    );

    ppu_cpu_regs regs_i (
        .clk, .rst_n, .cpu_req, .cpu_cmd, .vblank_set, .flags_clr, .nmi_window,
        .sp_zero_set, .pal_rdata(pal_cpu_rdata), .cpu_ack, .cpu_rdata, .ctrl, .mask,
        .pal_waddr, .pal_we, .pal_wdata, .nmi_n
    );

    // cpu reads and writes the palette through the same pointer
    ppu_palette_ram pal_i (
        .clk, .rst_n, .we(pal_we), .waddr(pal_waddr), .wdata(pal_wdata),
        .raddr_a(pal_addr), .raddr_b(pal_waddr),
        .rdata_a(pal_color), .rdata_b(pal_cpu_rdata)
    );

    ppu_pixel_mux mux_i (
        .pix(pix_in), .dot, .mask, .line_wr, .pal_color,
        .pal_addr, .pixel, .sp_zero_set
    );

    ppu_line_buffer lbuf_i (
        .clk, .rst_n, .line_wr, .wr_idx(dot[7:0]), .wr_pixel(pixel),
        .line_end, .rd_idx(line_idx), .rd_pixel(line_pixel)
    );

endmodule

// File: ppu_top_assertions.sv
`include "ppu_settings.svh"

module ppu_top_assertions (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cpu_req,
    input  logic             cpu_ack,
    input  logic             nmi_n,
    input  ppu_pkg::ctrl_t   ctrl,
    input  ppu_pkg::mask_t   mask,
    input  logic [8:0]       dot,
    input  logic [8:0]       line,
    input  logic             line_wr,
    input  logic             line_end,
    input  ppu_pkg::pix_in_t pix_in,
    input  logic [7:0]       line_idx,
    input  logic [5:0]       line_pixel,
    input  logic             pal_we,
    input  logic [4:0]       pal_waddr,
    input  logic [5:0]       pal_wdata
);

    logic [5:0] pal_model [`PPU_PAL_ENTRIES];
    logic [5:0] hist_cur [`PPU_VISIBLE_DOTS];
    logic [5:0] hist_prev [`PPU_VISIBLE_DOTS];
    logic       cur_written;
    logic       prev_valid;
    logic [5:0] exp_pixel;
    logic [5:0] exp_line_pixel;
    logic       nmi_due;
    int         fail_count = 0;

    // backdrop entries of the sprite half fold onto the bg half
    function automatic logic [4:0] fold_addr(input logic [4:0] a);
        if (a[4] && a[1:0] == 2'b00) return {1'b0, a[3:0]};
        return a;
    endfunction

    function automatic logic [4:0] pick_addr(input ppu_pkg::pix_in_t p,
                                             input ppu_pkg::mask_t m,
                                             input logic [8:0] d);
        logic       clip;
        logic [3:0] bg;
        logic [3:0] sp;
        clip = (d < 9'(`PPU_CLIP_DOTS));
        bg = (m.bg_en && (m.bg_left || !clip)) ? p.bg_idx : 4'd0;
        sp = (m.sp_en && (m.sp_left || !clip)) ? p.sp_idx : 4'd0;
        if (bg[1:0] == 2'b00 && sp[1:0] == 2'b00) return {1'b0, bg};
        if (bg[1:0] == 2'b00) return {1'b1, sp};
        if (sp[1:0] == 2'b00) return {1'b0, bg};
        return p.sp_prio ? {1'b0, bg} : {1'b1, sp};
    endfunction

    assign exp_pixel = pal_model[fold_addr(pick_addr(pix_in, mask, dot))]
                       & (mask.grey ? `PPU_GREY_MASK : 6'h3f);
    assign exp_line_pixel = hist_prev[line_idx];
    assign nmi_due = (line == 9'(`PPU_VBLANK_LINE)) && (dot < 9'(`PPU_NMI_DOTS)) && ctrl.nmi_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PPU_PAL_ENTRIES; i++) pal_model[i] <= '0;
            cur_written <= 1'b0;
            prev_valid  <= 1'b0;
        end else begin
            if (pal_we) pal_model[fold_addr(pal_waddr)] <= pal_wdata;
            if (line_wr) cur_written <= 1'b1;
            if (line_end) begin
                prev_valid  <= cur_written;
                cur_written <= 1'b0;
            end
        end
    end

    // one line of expected pixels handed over at end of line
    always_ff @(posedge clk) begin
        if (line_wr) hist_cur[dot[7:0]] <= exp_pixel;
        if (line_end) hist_prev <= hist_cur;
    end

    ack_rise_a: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cpu_ack) |-> $past(cpu_req) && $past(cpu_req, 2))
        else begin
            fail_count++;
            $error("ack rose without req held for two edges");
        end

    ack_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ack && cpu_req |=> cpu_ack)
        else begin
            fail_count++;
            $error("ack dropped while req still high");
        end

    ack_fall_a: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ack && !cpu_req |=> !cpu_ack)
        else begin
            fail_count++;
            $error("ack did not fall one cycle after req fell");
        end

    nmi_a: assert property (@(posedge clk) disable iff (!rst_n)
        nmi_n != nmi_due)
        else begin
            fail_count++;
            $error("nmi_n low outside line 241 dots 0 to 2 or missing");
        end

    line_out_a: assert property (@(posedge clk) disable iff (!rst_n)
        prev_valid |-> line_pixel == exp_line_pixel)
        else begin
            fail_count++;
            $error("line_pixel differs from previous line history");
        end

endmodule

bind ppu_top ppu_top_assertions chk_i (
    .clk(clk), .rst_n(rst_n), .cpu_req(cpu_req), .cpu_ack(cpu_ack), .nmi_n(nmi_n),
    .ctrl(ctrl), .mask(mask), .dot(dot), .line(line), .line_wr(line_wr),
    .line_end(line_end), .pix_in(pix_in), .line_idx(line_idx), .line_pixel(line_pixel),
    .pal_we(pal_we), .pal_waddr(pal_waddr), .pal_wdata(pal_wdata)
);

// File: ppu_top_tb.sv
`include "ppu_settings.svh"

module ppu_top_tb;

    localparam int FRAME_CYCLES   = `PPU_DOTS_PER_LINE * `PPU_LINES_PER_FRAME;
    // three frames bound a run that ends in the second frame
    localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES;

    logic              clk;
    logic              rst_n;
    logic              cpu_req;
    ppu_pkg::cpu_cmd_t cpu_cmd;
    ppu_pkg::pix_in_t  pix_in;
    logic [7:0]        line_idx;
    logic              cpu_ack;
    logic [7:0]        cpu_rdata;
    logic              nmi_n;
    logic [5:0]        line_pixel;
    ppu_pkg::ctrl_t    ctrl;
    ppu_pkg::mask_t    mask;

    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          cycles;
    int          nmi_low_cycles;
    logic [7:0]  rd;

    ppu_top dut_i (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    // one four-phase transaction
    task automatic bus_xfer(input ppu_pkg::reg_sel_t sel, input logic write,
                            input logic [7:0] data, output logic [7:0] rdata);
        @(posedge clk);
        #1;
        cpu_cmd.sel   = sel;
        cpu_cmd.write = write;
        cpu_cmd.data  = data;
        cpu_req       = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!cpu_ack);
        // slow requester keeps req up for one more cycle
        @(posedge clk);
        #1;
        rdata   = cpu_rdata;
        cpu_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (cpu_ack);
    endtask

    task automatic wait_line(input int n);
        do @(posedge clk); while (dut_i.line != 9'(n));
        #1;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // random pixels and read index on every dot
    always @(posedge clk) begin
        #1;
        rng_state = xorshift32(rng_state);
        pix_in    = rng_state[9:0];
        line_idx  = rng_state[17:10];
    end

    always @(negedge clk) begin
        if (rst_n && !nmi_n) nmi_low_cycles++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d errors", cycles, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic [7:0] masks [8];
        masks = '{8'h1f, 8'h1e, 8'h19, 8'h0f, 8'h17, 8'h01, 8'h1d, 8'h1b};
        rng_state = 32'd26318;
        errors = 0;
        checks = 0;
        cycles = 0;
        nmi_low_cycles = 0;
        rst_n = 1'b0;
        cpu_req = 1'b0;
        cpu_cmd = '0;
        pix_in = '0;
        line_idx = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_val("cpu_ack", 8'h00, {7'd0, cpu_ack});
        check_val("nmi_n", 8'h01, {7'd0, nmi_n});
        check_val("ctrl", 8'h00, ctrl);
        check_val("mask", 8'h00, mask);

        bus_xfer(ppu_pkg::REG_CTRL, 1'b1, 8'h80, rd);
        check_val("ctrl", 8'h80, ctrl);
        check_val("cpu_rdata", 8'h80, rd);
        bus_xfer(ppu_pkg::REG_CTRL, 1'b0, 8'h00, rd);
        check_val("cpu_rdata", 8'h80, rd);
        bus_xfer(ppu_pkg::REG_CTRL, 1'b1, 8'h00, rd);
        bus_xfer(ppu_pkg::REG_MASK, 1'b1, 8'h1f, rd);
        check_val("mask", 8'h1f, mask);
        bus_xfer(ppu_pkg::REG_MASK, 1'b0, 8'h00, rd);
        check_val("cpu_rdata", 8'h1f, rd);

        // backdrops end up holding the sprite-half value after the identity fill
        bus_xfer(ppu_pkg::REG_PAL_ADDR, 1'b1, 8'h00, rd);
        for (int i = 0; i < 32; i++) bus_xfer(ppu_pkg::REG_PAL_DATA, 1'b1, 8'(i), rd);
        bus_xfer(ppu_pkg::REG_PAL_ADDR, 1'b1, 8'h00, rd);
        for (int i = 0; i < 32; i++) begin
            bus_xfer(ppu_pkg::REG_PAL_DATA, 1'b0, 8'h00, rd);
            check_val("palette", (i % 4 == 0) ? 8'(i | 16) : 8'(i), rd);
        end
        // entry 00 cleared so only the mirrored write can set it
        bus_xfer(ppu_pkg::REG_PAL_ADDR, 1'b1, 8'h00, rd);
        bus_xfer(ppu_pkg::REG_PAL_DATA, 1'b1, 8'h00, rd);
        bus_xfer(ppu_pkg::REG_PAL_ADDR, 1'b1, 8'h10, rd);
        bus_xfer(ppu_pkg::REG_PAL_DATA, 1'b1, 8'h10, rd);
        bus_xfer(ppu_pkg::REG_PAL_ADDR, 1'b1, 8'h00, rd);
        bus_xfer(ppu_pkg::REG_PAL_DATA, 1'b0, 8'h00, rd);
        check_val("palette[00]", 8'h10, rd);

        wait_line(5);
        bus_xfer(ppu_pkg::REG_STATUS, 1'b0, 8'h00, rd);
        check_val("status", 8'h40, rd);

        for (int k = 0; k < 8; k++) begin
            wait_line(10 + 25 * k);
            bus_xfer(ppu_pkg::REG_MASK, 1'b1, masks[k], rd);
            check_val("mask", masks[k], mask);
        end

        // nmi disabled for this frame
        wait_line(242);
        check_val("nmi_low_cycles", 8'd0, 8'(nmi_low_cycles));
        bus_xfer(ppu_pkg::REG_MASK, 1'b1, 8'h00, rd);
        wait_line(1);
        bus_xfer(ppu_pkg::REG_STATUS, 1'b0, 8'h00, rd);
        check_val("status", 8'h00, rd);

        bus_xfer(ppu_pkg::REG_CTRL, 1'b1, 8'h80, rd);
        bus_xfer(ppu_pkg::REG_MASK, 1'b1, 8'h1e, rd);
        nmi_low_cycles = 0;
        wait_line(242);
        check_val("nmi_low_cycles", 8'd3, 8'(nmi_low_cycles));
        bus_xfer(ppu_pkg::REG_STATUS, 1'b0, 8'h00, rd);
        check_val("status[7]", 8'h01, {7'd0, rd[7]});
        bus_xfer(ppu_pkg::REG_STATUS, 1'b0, 8'h00, rd);
        check_val("status[7]", 8'h00, {7'd0, rd[7]});

        $display("checks=%0d errors=%0d assert_fails=%0d", checks, errors,
                 dut_i.chk_i.fail_count);
        if (errors == 0 && dut_i.chk_i.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: ppu_top.f
+incdir+.
ppu_pkg.sv
ppu_frame_timing.sv
ppu_cpu_regs.sv
ppu_palette_ram.sv
ppu_pixel_mux.sv
ppu_line_buffer.sv
ppu_top.sv
ppu_top_assertions.sv
ppu_top_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ppu_top_tb
RTL_TOP   ?= ppu_top
FLIST     ?= ppu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
